//--- verilog/uart_pkg.sv
`default_nettype none

// Shared definitions for the Wishbone UART
package uart_pkg;

    // Register word addresses on the Wishbone port
    // Addresses 2 and 3 are unmapped
    typedef enum logic [1:0] {
        REG_DATA   = 2'd0,
        REG_STATUS = 2'd1
    } reg_addr_e;

    // Bit positions inside the 8-bit status value
    localparam int STAT_RX_VALID  = 0;
    localparam int STAT_TX_BUSY   = 1;
    // Sticky, cleared by any write to the status register
    localparam int STAT_FRAME_ERR = 2;
    localparam int STAT_OVERRUN   = 3;

    // Receiver states, in the order the FSM walks them
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_CHECK_START,
        RX_SAMPLE_BITS,
        RX_READ_BITS,
        RX_CHECK_STOP,
        RX_ERROR,
        RX_DELAY_RESTART,
        RX_RECEIVED
    } rx_state_e;

    // Transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SENDING,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

// UART receiver with start check, 5-sample majority vote and stop check
module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        rx,
    output logic [7:0] rx_byte,
    output logic       rx_done,
    output logic       rx_error,
    output logic       rx_busy
);

    // Timer must hold the restart delay of eight bit periods
    localparam int TW = $clog2(8 * CLKS_PER_BIT);

    // Wait values are loaded as length minus one
    // Half a bit, to reach the middle of start and stop bits
    localparam logic [TW-1:0] HALF_WAIT = TW'(CLKS_PER_BIT / 2 - 1);
    // From mid start bit to 3/8 into data bit 0
    localparam logic [TW-1:0] FIRST_WAIT =
        TW'(CLKS_PER_BIT / 2 + (CLKS_PER_BIT * 3) / 8 - 1);
    // Spacing between the five samples
    localparam logic [TW-1:0] STEP_WAIT = TW'(CLKS_PER_BIT / 8 - 1);
    // From end of one bit to 3/8 into the next
    localparam logic [TW-1:0] NEXT_WAIT = TW'((CLKS_PER_BIT * 3) / 8 - 1);
    // Line is ignored this long after an error
    localparam logic [TW-1:0] RESTART_WAIT = TW'(8 * CLKS_PER_BIT - 1);

    uart_pkg::rx_state_e rx_state;

    logic          rx_meta;
    logic          rx_sync;
    logic [TW-1:0] rx_timer;
    logic [3:0]    bits_left;
    logic [2:0]    sample_cnt;
    logic [2:0]    ones;
    logic          bit_value;
    logic          bit_read;

    // Two-flop synchronizer, idle line is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Majority of five samples
    assign bit_value = (ones >= 3'd3);
    assign bit_read  = (rx_state == uart_pkg::RX_READ_BITS) && (rx_timer == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state   <= uart_pkg::RX_IDLE;
            rx_timer   <= '0;
            bits_left  <= 4'd0;
            sample_cnt <= 3'd0;
            ones       <= 3'd0;
        end else begin
            // Free-running countdown, state loads below take priority
            if (rx_timer != '0) begin
                rx_timer <= rx_timer - 1'b1;
            end

            case (rx_state)
                uart_pkg::RX_IDLE: begin
                    // Falling edge on the line may be a start bit
                    if (!rx_sync) begin
                        rx_timer <= HALF_WAIT;
                        rx_state <= uart_pkg::RX_CHECK_START;
                    end
                end

                uart_pkg::RX_CHECK_START: begin
                    if (rx_timer == '0) begin
                        // Start must still be low at mid bit
                        if (!rx_sync) begin
                            rx_timer   <= FIRST_WAIT;
                            bits_left  <= 4'd8;
                            sample_cnt <= 3'd5;
                            ones       <= 3'd0;
                            rx_state   <= uart_pkg::RX_SAMPLE_BITS;
                        end else begin
                            // Too short to be a start bit
                            rx_state <= uart_pkg::RX_ERROR;
                        end
                    end
                end

                uart_pkg::RX_SAMPLE_BITS: begin
                    if (rx_timer == '0) begin
                        ones       <= ones + {2'b00, rx_sync};
                        sample_cnt <= sample_cnt - 3'd1;
                        rx_timer   <= STEP_WAIT;
                        // Fifth sample taken, decide at end of bit
                        if (sample_cnt == 3'd1) begin
                            rx_state <= uart_pkg::RX_READ_BITS;
                        end
                    end
                end

                uart_pkg::RX_READ_BITS: begin
                    if (rx_timer == '0) begin
                        bits_left  <= bits_left - 4'd1;
                        ones       <= 3'd0;
                        sample_cnt <= 3'd5;
                        if (bits_left == 4'd1) begin
                            // Last data bit, go to mid stop bit
                            rx_timer <= HALF_WAIT;
                            rx_state <= uart_pkg::RX_CHECK_STOP;
                        end else begin
                            rx_timer <= NEXT_WAIT;
                            rx_state <= uart_pkg::RX_SAMPLE_BITS;
                        end
                    end
                end

                uart_pkg::RX_CHECK_STOP: begin
                    // Low stop bit is a framing error
                    if (rx_timer == '0) begin
                        rx_state <= rx_sync ? uart_pkg::RX_RECEIVED : uart_pkg::RX_ERROR;
                    end
                end

                uart_pkg::RX_ERROR: begin
                    // One cycle here gives the error pulse
                    rx_timer <= RESTART_WAIT;
                    rx_state <= uart_pkg::RX_DELAY_RESTART;
                end

                uart_pkg::RX_DELAY_RESTART: begin
                    if (rx_timer == '0) begin
                        rx_state <= uart_pkg::RX_IDLE;
                    end
                end

                uart_pkg::RX_RECEIVED: begin
                    rx_state <= uart_pkg::RX_IDLE;
                end

                default: begin
                    rx_state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data shifter, LSB arrives first
    always_ff @(posedge clk) begin
        if (bit_read) begin
            rx_byte <= {bit_value, rx_byte[7:1]};
        end
    end

    assign rx_done  = (rx_state == uart_pkg::RX_RECEIVED);
    assign rx_error = (rx_state == uart_pkg::RX_ERROR);
    assign rx_busy  = (rx_state != uart_pkg::RX_IDLE);

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

// UART transmitter, start bit, eight data bits LSB first, stop interval
module uart_tx #(
    parameter int CLKS_PER_BIT = 16,
    parameter int STOP_BITS    = 2
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        tx_start,
    input  wire  [7:0] tx_byte,
    output logic       tx,
    output logic       tx_busy
);

    // Timer sized for the longest wait, the stop interval
    localparam int TW = $clog2(STOP_BITS * CLKS_PER_BIT);

    // Loaded as length minus one
    localparam logic [TW-1:0] BIT_WAIT  = TW'(CLKS_PER_BIT - 1);
    localparam logic [TW-1:0] STOP_WAIT = TW'(STOP_BITS * CLKS_PER_BIT - 1);

    uart_pkg::tx_state_e tx_state;

    logic [TW-1:0] tx_timer;
    logic [3:0]    bits_left;
    logic [7:0]    shift_reg;
    logic          tx_load;
    logic          tx_shift;

    // Accept a byte only when idle
    assign tx_load  = (tx_state == uart_pkg::TX_IDLE) && tx_start;
    // Next data bit goes out at the end of each bit period
    assign tx_shift = (tx_state == uart_pkg::TX_SENDING) && (tx_timer == '0) &&
                      (bits_left != 4'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state  <= uart_pkg::TX_IDLE;
            tx        <= 1'b1;
            tx_timer  <= '0;
            bits_left <= 4'd0;
        end else begin
            if (tx_timer != '0) begin
                tx_timer <= tx_timer - 1'b1;
            end

            case (tx_state)
                uart_pkg::TX_IDLE: begin
                    // Start bit begins on the edge that sees the pulse
                    if (tx_load) begin
                        tx        <= 1'b0;
                        tx_timer  <= BIT_WAIT;
                        bits_left <= 4'd8;
                        tx_state  <= uart_pkg::TX_SENDING;
                    end
                end

                uart_pkg::TX_SENDING: begin
                    if (tx_shift) begin
                        tx        <= shift_reg[0];
                        bits_left <= bits_left - 4'd1;
                        tx_timer  <= BIT_WAIT;
                    end else if (tx_timer == '0) begin
                        // All data bits out, hold the stop level
                        tx       <= 1'b1;
                        tx_timer <= STOP_WAIT;
                        tx_state <= uart_pkg::TX_STOP;
                    end
                end

                uart_pkg::TX_STOP: begin
                    if (tx_timer == '0) begin
                        tx_state <= uart_pkg::TX_IDLE;
                    end
                end

                default: begin
                    tx       <= 1'b1;
                    tx_state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Byte shifter, bit 0 always holds the next bit to send
    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift_reg <= tx_byte;
        end else if (tx_shift) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // Busy through start, data and the whole stop interval
    assign tx_busy = (tx_state != uart_pkg::TX_IDLE);

endmodule

`default_nettype wire

//--- verilog/uart_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic slave with the data and status registers
module uart_wb_regs (
    input  wire        clk,
    input  wire        rst,
    // Wishbone slave
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    input  wire  [1:0] adr,
    input  wire  [7:0] dat_w,
    output logic [7:0] dat_r,
    output logic       ack,
    // Transmitter side
    output logic       tx_start,
    output logic [7:0] tx_byte,
    input  wire        tx_busy,
    // Receiver side
    input  wire  [7:0] rx_byte,
    input  wire        rx_done,
    input  wire        rx_error
);

    uart_pkg::reg_addr_e reg_sel;

    logic       req;
    logic       wr_data;
    logic       wr_status;
    logic       rd_data;
    logic       tx_accept;
    logic       rx_valid;
    logic       frame_err;
    logic       overrun;
    logic [7:0] rx_hold;
    logic [7:0] status;

    // New request only, a high ack holds off a second accept
    assign req     = cyc && stb && !ack;
    assign reg_sel = uart_pkg::reg_addr_e'(adr);

    assign wr_data   = req && we && (reg_sel == uart_pkg::REG_DATA);
    assign wr_status = req && we && (reg_sel == uart_pkg::REG_STATUS);
    assign rd_data   = req && !we && (reg_sel == uart_pkg::REG_DATA);

    // Data write while sending is acked but dropped
    assign tx_accept = wr_data && !tx_busy && !tx_start;

    // Registered ack, one cycle per transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Start pulse lasts a single cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_byte <= dat_w;
        end
    end

    // Receive holding register, a new byte always replaces the old one
    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_hold <= rx_byte;
        end
    end

    // Status flags, a set event wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (rx_done) begin
                rx_valid <= 1'b1;
            end else if (rd_data) begin
                rx_valid <= 1'b0;
            end

            // Unread byte lost, unless it is read on this very edge
            if (rx_done && rx_valid && !rd_data) begin
                overrun <= 1'b1;
            end else if (wr_status) begin
                overrun <= 1'b0;
            end

            if (rx_error) begin
                frame_err <= 1'b1;
            end else if (wr_status) begin
                frame_err <= 1'b0;
            end
        end
    end

    // Status value, busy is taken live from the transmitter
    always_comb begin
        status = 8'h00;
        status[uart_pkg::STAT_RX_VALID]  = rx_valid;
        status[uart_pkg::STAT_TX_BUSY]   = tx_busy;
        status[uart_pkg::STAT_FRAME_ERR] = frame_err;
        status[uart_pkg::STAT_OVERRUN]   = overrun;
    end

    // Read data, valid while ack is high
    always_ff @(posedge clk) begin
        if (req && !we) begin
            case (reg_sel)
                uart_pkg::REG_DATA:   dat_r <= rx_hold;
                uart_pkg::REG_STATUS: dat_r <= status;
                default:              dat_r <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

// UART with a Wishbone classic register port
module uart_top #(
    parameter int SYS_CLK_FREQ = 10_000_000,
    parameter int BAUD_RATE    = 625_000,
    parameter int STOP_BITS    = 2
) (
    input  wire        clk,
    input  wire        rst,
    // Wishbone slave
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    input  wire  [1:0] adr,
    input  wire  [7:0] dat_w,
    output wire  [7:0] dat_r,
    output wire        ack,
    // Serial line
    input  wire        rx,
    output wire        tx
);

    // Bit period in clocks, at least 16 for the eighth-bit sampling
    localparam int CLKS_PER_BIT = SYS_CLK_FREQ / BAUD_RATE;

    wire       tx_start;
    wire [7:0] tx_byte;
    wire       tx_busy;
    wire [7:0] rx_byte;
    wire       rx_done;
    wire       rx_error;
    // Receiver activity, observed by the checker
    wire       rx_busy;

    uart_wb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done),
        .rx_error (rx_error)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done),
        .rx_error (rx_error),
        .rx_busy  (rx_busy)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .STOP_BITS    (STOP_BITS)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

//--- sim/uart_chk.sv
`timescale 1ns/100ps
`default_nettype none

// Protocol checks on the UART bus and serial line
module uart_chk (
    input  wire       clk,
    input  wire       rst,
    input  wire       cyc,
    input  wire       stb,
    input  wire       we,
    input  wire [1:0] adr,
    input  wire       ack,
    input  wire       tx,
    input  wire [1:0] tx_state,
    input  wire       rx,
    input  wire       rx_busy
);

    // New data write to an idle transmitter, start bit on the edge after the ack edge
    data_write_starts_frame: assert property (@(posedge clk) disable iff (rst)
        $past(cyc && stb && we && !ack && (adr == uart_pkg::REG_DATA) &&
              (tx_state == uart_pkg::TX_IDLE), 2) |-> !tx)
        else $error("no start bit on tx after a data write");

    // Idle transmitter keeps the line at the mark level
    tx_idle_high: assert property (@(posedge clk) disable iff (rst)
        (tx_state == uart_pkg::TX_IDLE) |-> tx)
        else $error("tx low while the transmitter is idle");

    // Receiver leaves idle only for a low line, three clocks through sync and FSM
    rx_start_on_low: assert property (@(posedge clk) disable iff (rst)
        $rose(rx_busy) |-> !$past(rx, 3))
        else $error("receiver started while the line was high");

endmodule

bind uart_top uart_chk chk_i (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .ack      (ack),
    .tx       (tx),
    .tx_state (u_tx.tx_state),
    .rx       (rx),
    .rx_busy  (rx_busy)
);

`default_nettype wire

//--- sim/tb_uart.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the Wishbone UART
module tb_uart;

    localparam int SYS_CLK_FREQ = 10_000_000;
    localparam int BAUD_RATE    = 625_000;
    localparam int STOP_BITS    = 2;
    localparam int CLKS_PER_BIT = SYS_CLK_FREQ / BAUD_RATE;
    localparam int NUM_TX_BYTES = 8;
    localparam int NUM_RX_BYTES = 8;
    // Poll limit, well beyond one frame
    localparam int TIMEOUT      = 40 * CLKS_PER_BIT;

    logic       clk;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    logic [7:0] dat_w;
    logic [7:0] dat_r;
    logic       ack;
    logic       rx;
    logic       tx;

    int seed     = 35;
    int errors   = 0;

    // Reference model, one byte queue per direction plus flags
    logic [7:0] tx_q[$];
    logic [7:0] rx_q[$];
    logic       exp_rx_valid  = 1'b0;
    logic       exp_frame_err = 1'b0;
    logic       exp_overrun   = 1'b0;

    uart_top #(
        .SYS_CLK_FREQ (SYS_CLK_FREQ),
        .BAUD_RATE    (BAUD_RATE),
        .STOP_BITS    (STOP_BITS)
    ) dut_i (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .rx    (rx),
        .tx    (tx)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("errors: %0d", errors);
        $display("Test FAILED");
        $finish;
    endtask

    // One Wishbone classic transfer, request on the falling edge
    task automatic bus_cycle(input logic write, input logic [1:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        @(negedge clk);
        while (!ack) begin
            waited = waited + 1;
            if (waited > 16) abort_run("no Wishbone ack within 16 cycles");
            @(negedge clk);
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [7:0] wdata);
        logic [7:0] unused;
        bus_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [7:0] rdata);
        bus_cycle(1'b0, addr, 8'h00, rdata);
    endtask

    // Poll one status bit until it reaches the given level
    task automatic wait_status(input int pos, input logic level, input string what);
        logic [7:0] st;
        int polls;
        polls = 0;
        bus_read(uart_pkg::REG_STATUS, st);
        while (st[pos] != level) begin
            polls = polls + 1;
            if (polls > TIMEOUT) abort_run(what);
            bus_read(uart_pkg::REG_STATUS, st);
        end
    endtask

    // Stored flags against the model, busy bit masked
    task automatic check_flags(input string where);
        logic [7:0] st;
        logic [7:0] exp;
        bus_read(uart_pkg::REG_STATUS, st);
        exp = 8'h00;
        exp[uart_pkg::STAT_RX_VALID]  = exp_rx_valid;
        exp[uart_pkg::STAT_FRAME_ERR] = exp_frame_err;
        exp[uart_pkg::STAT_OVERRUN]   = exp_overrun;
        st[uart_pkg::STAT_TX_BUSY]    = 1'b0;
        if (st !== exp) begin
            errors = errors + 1;
            $display("error %0t: %s status %02h expected %02h", $time, where, st, exp);
        end
    endtask

    // Mid-bit decoder on tx, compared with the next queued byte
    task automatic check_frame();
        logic [7:0] data;
        logic [7:0] exp;
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            waited = waited + 1;
            if (waited > TIMEOUT) abort_run("no start bit seen on tx");
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        if (tx !== 1'b0) begin
            errors = errors + 1;
            $display("error %0t: start bit not low at mid bit", $time);
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        for (int i = 0; i < STOP_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (tx !== 1'b1) begin
                errors = errors + 1;
                $display("error %0t: stop bit %0d is low", $time, i);
            end
        end
        if (tx_q.size() == 0) begin
            errors = errors + 1;
            $display("error %0t: unexpected frame %02h on tx", $time, data);
        end else begin
            exp = tx_q.pop_front();
            if (data !== exp) begin
                errors = errors + 1;
                $display("error %0t: tx frame %02h expected %02h", $time, data, exp);
            end
        end
    endtask

    // Line driver, stop level chosen by the caller
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        @(negedge clk);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = data[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = stop_level;
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
    endtask

    // Holding register keeps only the newest byte
    task automatic model_receive(input logic [7:0] data);
        if (exp_rx_valid) begin
            exp_overrun = 1'b1;
            rx_q.delete(0);
        end
        rx_q.push_back(data);
        exp_rx_valid = 1'b1;
    endtask

    task automatic read_data_check();
        logic [7:0] got;
        logic [7:0] exp;
        bus_read(uart_pkg::REG_DATA, got);
        if (rx_q.size() == 0) begin
            errors = errors + 1;
            $display("error %0t: data read %02h with nothing received", $time, got);
        end else begin
            exp = rx_q.pop_front();
            if (got !== exp) begin
                errors = errors + 1;
                $display("error %0t: rx data %02h expected %02h", $time, got, exp);
            end
        end
        exp_rx_valid = 1'b0;
    endtask

    initial begin
        logic [7:0] b;
        logic [7:0] b2;
        logic [7:0] st;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = 2'd0;
        dat_w = 8'h00;
        rx    = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle state after reset
        bus_read(uart_pkg::REG_STATUS, st);
        if (st !== 8'h00) begin
            errors = errors + 1;
            $display("error %0t: status %02h after reset", $time, st);
        end
        repeat (4 * CLKS_PER_BIT) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                errors = errors + 1;
                $display("error %0t: tx not high after reset", $time);
            end
        end

        // Transmit path
        for (int n = 0; n < NUM_TX_BYTES; n++) begin
            b = 8'($random(seed));
            tx_q.push_back(b);
            bus_write(uart_pkg::REG_DATA, b);
            check_frame();
            wait_status(uart_pkg::STAT_TX_BUSY, 1'b0, "transmit busy never cleared");
        end

        // Write while busy is dropped
        b  = 8'($random(seed));
        b2 = 8'($random(seed));
        // Dropped byte must differ to be visible on the line
        if (b2 == b) b2 = ~b;
        tx_q.push_back(b);
        bus_write(uart_pkg::REG_DATA, b);
        fork
            check_frame();
            begin
                repeat (3 * CLKS_PER_BIT) @(negedge clk);
                bus_read(uart_pkg::REG_STATUS, st);
                if (st[uart_pkg::STAT_TX_BUSY] !== 1'b1) begin
                    errors = errors + 1;
                    $display("error %0t: transmit busy clear in the middle of a frame",
                             $time);
                end
                bus_write(uart_pkg::REG_DATA, b2);
            end
        join
        wait_status(uart_pkg::STAT_TX_BUSY, 1'b0, "transmit busy never cleared");
        repeat ((10 + STOP_BITS) * CLKS_PER_BIT) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                errors = errors + 1;
                $display("error %0t: extra frame after a write while busy", $time);
            end
        end

        // Receive path
        for (int n = 0; n < NUM_RX_BYTES; n++) begin
            b = 8'($random(seed));
            send_frame(b, 1'b1);
            model_receive(b);
            wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "receive valid never set");
            check_flags("after receive");
            read_data_check();
            check_flags("after data read");
        end

        // Framing error, restart delay, then a good frame
        send_frame(8'($random(seed)), 1'b0);
        exp_frame_err = 1'b1;
        wait_status(uart_pkg::STAT_FRAME_ERR, 1'b1, "framing error never flagged");
        check_flags("after framing error");
        repeat (9 * CLKS_PER_BIT) @(negedge clk);
        b = 8'($random(seed));
        send_frame(b, 1'b1);
        model_receive(b);
        wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "no receive after restart delay");
        read_data_check();
        check_flags("sticky framing error");
        bus_write(uart_pkg::REG_STATUS, 8'hff);
        exp_frame_err = 1'b0;
        check_flags("after status clear");

        // Overrun, second byte wins
        b  = 8'($random(seed));
        b2 = 8'($random(seed));
        // Second byte must differ so the winner can be told apart
        if (b2 == b) b2 = ~b;
        send_frame(b, 1'b1);
        model_receive(b);
        wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "receive valid never set");
        send_frame(b2, 1'b1);
        model_receive(b2);
        wait_status(uart_pkg::STAT_OVERRUN, 1'b1, "overrun never flagged");
        check_flags("after overrun");
        read_data_check();
        check_flags("overrun after read");
        bus_write(uart_pkg::REG_STATUS, 8'h00);
        exp_overrun = 1'b0;
        check_flags("after overrun clear");

        if (tx_q.size() != 0 || rx_q.size() != 0) begin
            errors = errors + 1;
            $display("error %0t: model queues not empty at the end", $time);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_wb_regs.sv
verilog/uart_top.sv
sim/uart_chk.sv
sim/tb_uart.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_uart
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)
